// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of the core's data words and word addresses
`define DATA_W 32

// Width of each pin group (address pins, bidirectional IO pins)
`define PIN_W 8

// One bus frame: phase 0 for the core step, 1 to 4 out, 5 to 8 back in
`define FRAME_LEN 9

// Word address of the first instruction fetch after reset
`define RESET_PC 0

`endif

// ==== isa_pkg.sv ====
package isa_pkg;

  // Four-bit operation codes in the top nibble of each instruction word
  typedef enum logic [3:0] {
    LDI  = 4'h0,  // Acc = sign-extended immediate
    LD   = 4'h1,  // Acc = mem[addr]
    ST   = 4'h2,  // Mem[addr] = acc
    ADD  = 4'h3,  // Acc = acc + mem[addr]
    SUB  = 4'h4,  // Acc = acc - mem[addr]
    AND  = 4'h5,  // Acc = acc & mem[addr]
    JMP  = 4'h6,  // Pc = addr
    JZ   = 4'h7,  // Pc = addr when acc is zero
    HALT = 4'h8   // Stop and keep reading the same address
  } opcode_e;

  // Memory operand layout
  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  rsvd;   // Ignored by the core
    logic [23:0] addr;   // Word address
  } mem_form_t;

  // Immediate layout, only LDI uses it
  typedef struct packed {
    opcode_e            opcode;
    logic signed [27:0] imm;
  } imm_form_t;

  // The opcode sits in the same bits in both forms, so either
  // view can be used to decode it
  typedef union packed {
    mem_form_t mem_form;
    imm_form_t imm_form;
  } instr_u;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

  // Position inside the nine-cycle frame, 0 to 8
  typedef logic [3:0] bus_phase_t;

  // Direction of the access carried by the current frame
  typedef enum logic {
    DIR_READ  = 1'b0,  // Pins float in phases 1 to 4, memory answers in 5 to 8
    DIR_WRITE = 1'b1   // IO pins driven with write data in phases 1 to 4
  } bus_dir_e;

endpackage

// ==== bus_phase_counter.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module bus_phase_counter
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  output bus_phase_t phase,
  output logic       cpu_step,
  output logic       frame_sync
);

  localparam bus_phase_t LAST_PHASE  = bus_phase_t'(`FRAME_LEN - 1);
  localparam bus_phase_t FIRST_PHASE = bus_phase_t'(1);

  // Starts in phase 1 so the reset fetch goes out straight away
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= FIRST_PHASE;
    end else if (phase == LAST_PHASE) begin
      phase <= '0;                        // Wrap to the core step
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign cpu_step   = (phase == '0);          // One cycle per frame
  assign frame_sync = (phase == FIRST_PHASE); // Marks first address byte

endmodule

// ==== pin_bus_mux.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module pin_bus_mux
  import bus_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  bus_phase_t         phase,
  input  logic [`DATA_W-1:0] bus_addr,
  input  logic [`DATA_W-1:0] bus_wdata,
  input  bus_dir_e           bus_dir,
  input  logic [`PIN_W-1:0]  io_in,
  output logic [`DATA_W-1:0] rd_data,
  output logic [`PIN_W-1:0]  addr_pins,
  output logic [`PIN_W-1:0]  io_out,
  output logic [`PIN_W-1:0]  io_oe
);

  localparam bus_phase_t OUT_FIRST = bus_phase_t'(1);
  localparam bus_phase_t OUT_LAST  = bus_phase_t'(4);
  localparam bus_phase_t IN_FIRST  = bus_phase_t'(5);
  localparam bus_phase_t IN_LAST   = bus_phase_t'(8);

  logic       out_window;  // Address and write bytes on the pins
  logic       in_window;   // Memory drives read bytes
  logic [1:0] lane;        // Byte lane, least significant first

  assign out_window = (phase >= OUT_FIRST) && (phase <= OUT_LAST);
  assign in_window  = (phase >= IN_FIRST) && (phase <= IN_LAST);

  // Phases 1..4 and 5..8 both map to lanes 0..3 through the low two bits
  assign lane = phase[1:0] - 2'd1;

  always_comb begin
    addr_pins = '0;
    io_out    = '0;
    io_oe     = '0;
    if (out_window) begin
      addr_pins = bus_addr[lane*`PIN_W +: `PIN_W];
      io_out    = bus_wdata[lane*`PIN_W +: `PIN_W];
      io_oe     = {`PIN_W{bus_dir == DIR_WRITE}}; // All or nothing
    end
  end

  // Read word fills one byte per cycle, whole after phase 8
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
    end else if (in_window) begin
      rd_data[lane*`PIN_W +: `PIN_W] <= io_in;
    end
  end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_core
  import isa_pkg::*;
  import bus_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cpu_step,
  input  logic [`DATA_W-1:0] rd_data,
  output logic [`DATA_W-1:0] bus_addr,
  output logic [`DATA_W-1:0] bus_wdata,
  output bus_dir_e           bus_dir,
  output logic               halted
);

  logic [`DATA_W-1:0] pc;
  logic [`DATA_W-1:0] acc;
  instr_u             instr;     // Instruction under execution
  instr_u             fetched;   // Word just returned by the fetch frame
  logic               in_exec;   // Low in fetch, high in execute
  logic [`DATA_W-1:0] pc_inc;
  logic [`DATA_W-1:0] fetch_tgt; // Operand address of the fetched word
  logic [`DATA_W-1:0] jump_tgt;  // Operand address of the held word
  logic [`DATA_W-1:0] imm_ext;
  logic [`DATA_W-1:0] exec_pc;

  localparam int ADDR_FW = $bits(instr.mem_form.addr);
  localparam int IMM_W   = $bits(instr.imm_form.imm);

  assign fetched   = rd_data;
  assign pc_inc    = pc + 1'b1;
  assign fetch_tgt = {{(`DATA_W - ADDR_FW){1'b0}}, fetched.mem_form.addr};
  assign jump_tgt  = {{(`DATA_W - ADDR_FW){1'b0}}, instr.mem_form.addr};

  // LDI reads the same word through its immediate view
  assign imm_ext = {{(`DATA_W - IMM_W){instr.imm_form.imm[IMM_W-1]}},
                    instr.imm_form.imm};

  always_comb begin
    exec_pc = pc_inc;
    if (instr.mem_form.opcode == JMP) begin
      exec_pc = jump_tgt;
    end else if (instr.mem_form.opcode == JZ && acc == '0) begin
      exec_pc = jump_tgt;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= `RESET_PC;
      acc       <= '0;
      in_exec   <= 1'b0;
      halted    <= 1'b0;
      bus_addr  <= `RESET_PC;         // First frame fetches from here
      bus_wdata <= '0;
      bus_dir   <= DIR_READ;
    end else if (cpu_step && !halted) begin
      if (!in_exec) begin
        // Fetch word is in rd_data; set up the second frame
        case (fetched.mem_form.opcode)
          LD, ADD, SUB, AND: begin
            bus_addr <= fetch_tgt;
            bus_dir  <= DIR_READ;
            in_exec  <= 1'b1;
          end
          ST: begin
            bus_addr  <= fetch_tgt;
            bus_wdata <= acc;
            bus_dir   <= DIR_WRITE;
            in_exec   <= 1'b1;
          end
          HALT: begin
            halted <= 1'b1;            // Request stays a read of pc
          end
          default: begin
            bus_addr <= pc_inc;        // Idle read, data is dropped
            bus_dir  <= DIR_READ;
            in_exec  <= 1'b1;
          end
        endcase
      end else begin
        case (instr.mem_form.opcode)
          LDI:     acc <= imm_ext;
          LD:      acc <= rd_data;
          ADD:     acc <= acc + rd_data;
          SUB:     acc <= acc - rd_data;
          AND:     acc <= acc & rd_data;
          default: acc <= acc;         // ST and jumps keep acc
        endcase
        pc       <= exec_pc;
        bus_addr <= exec_pc;           // Next fetch
        bus_dir  <= DIR_READ;
        in_exec  <= 1'b0;
      end
    end
  end

  // Held only while the data or idle frame runs
  always_ff @(posedge clk) begin
    if (cpu_step && !halted && !in_exec) begin
      instr <= fetched;
    end
  end

endmodule

// ==== cpu_pin_bridge_top.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_pin_bridge_top
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  output logic [`PIN_W-1:0] addr_pins,
  input  logic [`PIN_W-1:0] io_in,
  output logic [`PIN_W-1:0] io_out,
  output logic [`PIN_W-1:0] io_oe,
  output logic              frame_sync,
  output logic              halted
);

  bus_phase_t         phase;
  logic               cpu_step;
  logic [`DATA_W-1:0] bus_addr;
  logic [`DATA_W-1:0] bus_wdata;
  logic [`DATA_W-1:0] rd_data;
  bus_dir_e           bus_dir;

  bus_phase_counter u_phase_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .phase      (phase),
    .cpu_step   (cpu_step),
    .frame_sync (frame_sync)
  );

  cpu_core u_cpu_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpu_step  (cpu_step),
    .rd_data   (rd_data),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_dir   (bus_dir),
    .halted    (halted)
  );

  pin_bus_mux u_pin_bus_mux (
    .clk       (clk),
    .arst_n    (arst_n),
    .phase     (phase),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_dir   (bus_dir),
    .io_in     (io_in),
    .rd_data   (rd_data),
    .addr_pins (addr_pins),
    .io_out    (io_out),
    .io_oe     (io_oe)
  );

endmodule

// ==== cpu_pin_bridge_properties.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_pin_bridge_properties
  import bus_pkg::*;
(
  input logic              clk,
  input logic              arst_n,
  input bus_phase_t        phase,
  input logic [`PIN_W-1:0] io_oe,
  input logic              frame_sync,
  input logic              halted
);

  logic [3:0] since_sync;  // Cycles since the last frame_sync
  logic       sync_seen;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      since_sync <= '0;
      sync_seen  <= 1'b0;
    end else if (frame_sync) begin
      since_sync <= 4'd1;
      sync_seen  <= 1'b1;
    end else begin
      since_sync <= since_sync + 1'b1;
    end
  end

  oe_all_or_none: assert property (@(posedge clk) disable iff (!arst_n)
    (io_oe == '0) || (io_oe == '1))
    else $error("io_oe partly enabled: %h", io_oe);

  oe_only_out_phases: assert property (@(posedge clk) disable iff (!arst_n)
    !((phase >= 4'd1) && (phase <= 4'd4)) |-> (io_oe == '0))
    else $error("io_oe set in phase %0d", phase);

  sync_period: assert property (@(posedge clk) disable iff (!arst_n)
    sync_seen |-> (frame_sync == (since_sync == 4'(`FRAME_LEN))))
    else $error("frame_sync off its period, %0d cycles since last", since_sync);

  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) !$fell(halted))
    else $error("halted dropped without reset");

endmodule

bind cpu_pin_bridge_top cpu_pin_bridge_properties u_properties (
  .clk        (clk),
  .arst_n     (arst_n),
  .phase      (phase),
  .io_oe      (io_oe),
  .frame_sync (frame_sync),
  .halted     (halted)
);

// ==== cpu_pin_bridge_tb.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_pin_bridge_tb
  import isa_pkg::*;
  import bus_pkg::*;
();

  localparam int MEM_WORDS   = 256;
  localparam int MAX_INSTR   = 200;  // Bound on the reference run
  localparam int HALT_FRAMES = 4;    // Frames checked after HALT
  localparam int MAX_CYCLES  = 4000; // About 60 instructions of 18 cycles plus margin

  logic              clk;
  logic              arst_n;
  logic [`PIN_W-1:0] io_in;
  logic [`PIN_W-1:0] addr_pins;
  logic [`PIN_W-1:0] io_out;
  logic [`PIN_W-1:0] io_oe;
  logic              frame_sync;
  logic              halted;

  logic [`DATA_W-1:0] mem_model [MEM_WORDS];  // External memory behind the pins
  logic [`DATA_W-1:0] ref_mem   [MEM_WORDS];  // ISA model's own copy
  logic [`DATA_W-1:0] ref_pc;
  logic [`DATA_W-1:0] ref_acc;
  logic               ref_halted;

  bus_dir_e           exp_dir_q [$];
  logic [`DATA_W-1:0] exp_addr_q [$];
  logic [`DATA_W-1:0] exp_data_q [$];
  bus_dir_e           obs_dir_q [$];
  logic [`DATA_W-1:0] obs_addr_q [$];
  logic [`DATA_W-1:0] obs_data_q [$];

  int                 cur_phase;
  bit                 tracking;
  logic [`DATA_W-1:0] frm_addr;
  logic [`DATA_W-1:0] frm_data;
  logic [`PIN_W-1:0]  frm_oe;
  int                 errors;
  int                 frames_checked;
  int                 halt_frames;
  int                 cycles;
  integer             seed;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  cpu_pin_bridge_top uut (
    .clk        (clk),
    .arst_n     (arst_n),
    .addr_pins  (addr_pins),
    .io_in      (io_in),
    .io_out     (io_out),
    .io_oe      (io_oe),
    .frame_sync (frame_sync),
    .halted     (halted)
  );

  task automatic report_mismatch(string name, logic [`DATA_W-1:0] got,
                                 logic [`DATA_W-1:0] exp);
    errors++;
    $display("mismatch %s: got %0h, expected %0h at %0t", name, got, exp, $time);
  endtask

  function automatic void push_access(bus_dir_e dir, logic [`DATA_W-1:0] addr,
                                      logic [`DATA_W-1:0] data);
    exp_dir_q.push_back(dir);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endfunction

  function automatic logic [`DATA_W-1:0] mem_instr(opcode_e op, logic [23:0] addr);
    instr_u w;
    w.mem_form.opcode = op;
    w.mem_form.rsvd   = 4'h0;
    w.mem_form.addr   = addr;
    return w;
  endfunction

  function automatic logic [`DATA_W-1:0] imm_instr(logic signed [27:0] imm);
    instr_u w;
    w.imm_form.opcode = LDI;
    w.imm_form.imm    = imm;
    return w;
  endfunction

  function automatic void put_word(int addr, logic [`DATA_W-1:0] word);
    mem_model[addr] = word;
    ref_mem[addr]   = word;
  endfunction

  // Steps the ISA model by one instruction and queues its frames
  function automatic void ref_step();
    instr_u             w;
    logic [`DATA_W-1:0] opnd_addr;
    logic [`DATA_W-1:0] opnd_data;
    logic [`DATA_W-1:0] next_pc;
    w         = ref_mem[ref_pc[7:0]];
    opnd_addr = {8'h00, w.mem_form.addr};
    opnd_data = ref_mem[opnd_addr[7:0]];
    next_pc   = ref_pc + 1;
    push_access(DIR_READ, ref_pc, '0);               // Instruction fetch
    case (w.mem_form.opcode)
      LD, ADD, SUB, AND: begin
        push_access(DIR_READ, opnd_addr, '0);
        case (w.mem_form.opcode)
          LD:      ref_acc = opnd_data;
          ADD:     ref_acc = ref_acc + opnd_data;
          SUB:     ref_acc = ref_acc - opnd_data;
          default: ref_acc = ref_acc & opnd_data;
        endcase
        ref_pc = next_pc;
      end
      ST: begin
        push_access(DIR_WRITE, opnd_addr, ref_acc);
        ref_mem[opnd_addr[7:0]] = ref_acc;
        ref_pc = next_pc;
      end
      LDI: begin
        push_access(DIR_READ, next_pc, '0);          // Idle read that the core drops
        ref_acc = $signed(w.imm_form.imm);
        ref_pc  = next_pc;
      end
      JMP: begin
        push_access(DIR_READ, next_pc, '0);
        ref_pc = opnd_addr;
      end
      JZ: begin
        push_access(DIR_READ, next_pc, '0);
        ref_pc = (ref_acc == '0) ? opnd_addr : next_pc;
      end
      HALT: ref_halted = 1'b1;                        // Pc stays on the HALT word
      default: begin
        push_access(DIR_READ, next_pc, '0);
        ref_pc = next_pc;
      end
    endcase
  endfunction

  task automatic load_program();
    logic [27:0] neg_imm;
    for (int a = 0; a < MEM_WORDS; a++) begin
      put_word(a, 32'hF0A5_0000 | a);                 // Undefined opcode fill
    end
    for (int a = 8'h80; a <= 8'h85; a++) begin
      put_word(a, $random(seed));                     // Random operands
    end
    put_word(8'h86, 32'd1);
    neg_imm     = $random(seed);
    neg_imm[27] = 1'b1;
    put_word(0,  mem_instr(LD,  24'h80));
    put_word(1,  mem_instr(ADD, 24'h81));
    put_word(2,  mem_instr(ST,  24'hA0));
    put_word(3,  mem_instr(SUB, 24'h82));
    put_word(4,  mem_instr(ST,  24'hA1));
    put_word(5,  mem_instr(AND, 24'h83));
    put_word(6,  mem_instr(ST,  24'hA2));
    put_word(7,  imm_instr(28'sd5));
    put_word(8,  mem_instr(ADD, 24'h84));
    put_word(9,  mem_instr(ST,  24'hA3));
    put_word(10, imm_instr(-28'sd3));
    put_word(11, mem_instr(ST,  24'hA4));
    put_word(12, imm_instr(28'sh800_0000));           // Most negative immediate
    put_word(13, mem_instr(ST,  24'hA5));
    put_word(14, imm_instr(neg_imm));
    put_word(15, mem_instr(ADD, 24'h85));
    put_word(16, mem_instr(ST,  24'hA6));
    put_word(17, mem_instr(JMP, 24'd19));
    put_word(18, mem_instr(HALT, 24'd0));             // Skipped by the jump
    put_word(19, imm_instr(28'sd0));
    put_word(20, mem_instr(JZ,  24'd22));             // Taken
    put_word(21, mem_instr(HALT, 24'd0));
    put_word(22, imm_instr(28'sd6));
    put_word(23, mem_instr(ST,  24'hA8));             // Loop counter
    put_word(24, mem_instr(LD,  24'hA8));             // Loop top
    put_word(25, mem_instr(JZ,  24'd30));             // Not taken until counter is zero
    put_word(26, mem_instr(SUB, 24'h86));
    put_word(27, mem_instr(ST,  24'hA8));
    put_word(28, mem_instr(JMP, 24'd24));
    put_word(29, mem_instr(HALT, 24'd0));
    put_word(30, mem_instr(ST,  24'hA9));
    put_word(31, mem_instr(HALT, 24'd0));
  endtask

  // Memory behind the pins with the phase counted from frame_sync
  always @(negedge clk) begin : pin_memory
    int lane;
    if (frame_sync) begin
      if (tracking && cur_phase != 0 && cur_phase != 1) begin
        errors++;
        $display("error: frame_sync arrived in the middle of a frame at %0t", $time);
      end
      cur_phase = 1;
      tracking  = 1'b1;
    end else if (tracking) begin
      cur_phase = (cur_phase == `FRAME_LEN - 1) ? 0 : cur_phase + 1;
      if (cur_phase == 1) begin
        errors++;
        $display("error: frame_sync missing at the start of a frame at %0t", $time);
      end
    end
    io_in = '0;
    if (tracking && cur_phase >= 1 && cur_phase <= 4) begin
      lane = cur_phase - 1;
      frm_addr[lane*`PIN_W +: `PIN_W] = addr_pins;
      frm_data[lane*`PIN_W +: `PIN_W] = io_out;
      if (cur_phase == 1) begin
        frm_oe = io_oe;
        if (io_oe != '0 && io_oe != '1) begin
          errors++;
          $display("mismatch io_oe: got %0h, expected 0 or ff at %0t", io_oe, $time);
        end
      end else if (io_oe != frm_oe) begin
        report_mismatch("io_oe", io_oe, frm_oe);
      end
      if (cur_phase == 4) begin
        if (frm_oe == '1) begin
          mem_model[frm_addr[7:0]] = frm_data;
        end
        obs_dir_q.push_back((frm_oe == '1) ? DIR_WRITE : DIR_READ);
        obs_addr_q.push_back(frm_addr);
        obs_data_q.push_back(frm_data);
      end
    end else if (tracking) begin
      if (io_oe != '0) report_mismatch("io_oe", io_oe, '0);
      if (addr_pins != '0) report_mismatch("addr_pins", addr_pins, '0);
      if (cur_phase == 0 && io_out != '0) report_mismatch("io_out", io_out, '0);
      if (cur_phase >= 5 && frm_oe == '0) begin
        lane  = cur_phase - 5;
        io_in = mem_model[frm_addr[7:0]][lane*`PIN_W +: `PIN_W];
      end
    end
  end

  initial begin : compare_frames
    bus_dir_e           od;
    bus_dir_e           ed;
    logic [`DATA_W-1:0] oa;
    logic [`DATA_W-1:0] ea;
    logic [`DATA_W-1:0] ow;
    logic [`DATA_W-1:0] ew;
    logic               after_halt;
    forever begin
      wait (obs_dir_q.size() > 0);
      od = obs_dir_q.pop_front();
      oa = obs_addr_q.pop_front();
      ow = obs_data_q.pop_front();
      if (exp_dir_q.size() > 0) begin
        ed         = exp_dir_q.pop_front();
        ea         = exp_addr_q.pop_front();
        ew         = exp_data_q.pop_front();
        after_halt = 1'b0;
      end else begin
        ed         = DIR_READ;                        // Repeated read of the HALT word
        ea         = ref_pc;
        ew         = '0;
        after_halt = 1'b1;
        halt_frames++;
      end
      if (od != ed) report_mismatch("bus_dir", od, ed);
      if (oa != ea) report_mismatch("bus_addr", oa, ea);
      if (ed == DIR_WRITE && ow != ew) report_mismatch("bus_wdata", ow, ew);
      if (halted != after_halt) report_mismatch("halted", halted, after_halt);
      frames_checked++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      errors++;
      $display("error: run did not finish within %0d cycles", MAX_CYCLES);
      $display("frames checked %0d, errors %0d", frames_checked, errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int n;
    arst_n         = 1'b0;
    io_in          = '0;
    seed           = 29449;
    errors         = 0;
    frames_checked = 0;
    halt_frames    = 0;
    cycles         = 0;
    cur_phase      = 0;
    tracking       = 1'b0;
    load_program();
    ref_pc     = `RESET_PC;
    ref_acc    = '0;
    ref_halted = 1'b0;
    n          = 0;
    while (!ref_halted && n < MAX_INSTR) begin
      ref_step();
      n++;
    end
    if (!ref_halted) begin
      errors++;
      $display("error: reference model never reached HALT");
    end
    repeat (3) @(negedge clk);
    if (io_oe != '0) report_mismatch("io_oe", io_oe, '0);
    if (halted != 1'b0) report_mismatch("halted", halted, 1'b0);
    arst_n = 1'b1;
    wait (halt_frames >= HALT_FRAMES);
    @(negedge clk);
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (mem_model[a] != ref_mem[a]) begin
        errors++;
        $display("mismatch mem[%0h]: got %0h, expected %0h", a, mem_model[a], ref_mem[a]);
      end
    end
    $display("frames checked %0d, errors %0d", frames_checked, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
isa_pkg.sv
bus_pkg.sv
bus_phase_counter.sv
pin_bus_mux.sv
cpu_core.sv
cpu_pin_bridge_top.sv
cpu_pin_bridge_properties.sv
cpu_pin_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_pin_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - bus_pkg.sv
      - bus_phase_counter.sv
      - pin_bus_mux.sv
      - cpu_core.sv
      - cpu_pin_bridge_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_pin_bridge_properties.sv
      - cpu_pin_bridge_tb.sv
